/* files.f */
src/shading_pkg.sv
src/geometry_pkg.sv
src/tri_setup.sv
src/shade_divider.sv
src/color_interp.sv
src/edge_walker.sv
src/frag_fifo.sv
src/raster_top.sv
verification/raster_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f files.f --top-module raster_tb -o raster_sim; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/raster_sim)
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "TB PASSED"; then
    exit 0
fi

echo "Pass line not found in simulation output"
exit 1

/* verification/raster_tb.sv */
module raster_tb
    import shading_pkg::*, geometry_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCREEN_W   = 640;
    localparam int SCREEN_H   = 480;
    localparam int FIFO_DEPTH = 16;

    logic      clk;
    logic      rst;
    logic      tri_valid;
    triangle_t tri_data;
    logic      busy;
    logic      frag_valid;
    fragment_t frag;
    logic      frag_ready;

    fragment_t   exp_q [$];
    fragment_t   expect_frag;
    triangle_t   tri_list [$];
    string       name_list [$];
    int          group_list [$];
    logic [31:0] lfsr_state;
    logic [31:0] ready_lfsr;
    int          error_count;
    int          check_count;
    int          frag_count;
    int          limit_cycles;
    int          seg_left;
    logic        seg_level;
    logic        ready_random;
    logic        full_seen;

    raster_top #(
        .X_BITS     (10),
        .Y_BITS     (9),
        .SCREEN_W   (SCREEN_W),
        .SCREEN_H   (SCREEN_H),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) raster_top_inst (
        .clk        (clk),
        .rst        (rst),
        .tri_valid  (tri_valid),
        .tri_data   (tri_data),
        .busy       (busy),
        .frag_valid (frag_valid),
        .frag       (frag),
        .frag_ready (frag_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int take_bits(inout logic [31:0] state, input int n);
        int value;
        int i;
        value = 0;
        for (i = 0; i < n; i++)
        begin
            state = lfsr_next(state);
            value = (value << 1) | int'(state[0]);
        end
        return value;
    endfunction

    function automatic int edge_fn(input int xa, ya, xb, yb, px, py);
        return (xb - xa) * (py - ya) - (yb - ya) * (px - xa);
    endfunction

    function automatic color_t rgb(input int r, g, b);
        color_t c;
        c.r = 8'(r);
        c.g = 8'(g);
        c.b = 8'(b);
        return c;
    endfunction

    function automatic triangle_t make_tri(input int x0, y0, x1, y1, x2, y2,
                                           input color_t c0, c1, c2);
        triangle_t t;
        t.v0.x = COORD_BITS'(x0);
        t.v0.y = COORD_BITS'(y0);
        t.v1.x = COORD_BITS'(x1);
        t.v1.y = COORD_BITS'(y1);
        t.v2.x = COORD_BITS'(x2);
        t.v2.y = COORD_BITS'(y2);
        t.colors.c0 = c0;
        t.colors.c1 = c1;
        t.colors.c2 = c2;
        return t;
    endfunction

    // Small triangle near a random base point, turned counter-clockwise
    function automatic triangle_t make_random_triangle();
        int     bx, by;
        int     x [3];
        int     y [3];
        color_t c [3];
        int     k;
        bx = take_bits(lfsr_state, 10) % 660;
        by = take_bits(lfsr_state, 9) % 500;
        for (k = 0; k < 3; k++)
        begin
            x[k] = bx + take_bits(lfsr_state, 5);
            y[k] = by + take_bits(lfsr_state, 5);
            c[k] = rgb(take_bits(lfsr_state, 8), take_bits(lfsr_state, 8),
                       take_bits(lfsr_state, 8));
        end
        if (edge_fn(x[0], y[0], x[1], y[1], x[2], y[2]) < 0)
            return make_tri(x[0], y[0], x[2], y[2], x[1], y[1], c[0], c[1], c[2]);
        return make_tri(x[0], y[0], x[1], y[1], x[2], y[2], c[0], c[1], c[2]);
    endfunction

    function automatic int box_pixels(input triangle_t t);
        int lo_x, lo_y, hi_x, hi_y;
        lo_x = t.v0.x < t.v1.x ? t.v0.x : t.v1.x;
        lo_x = t.v2.x < lo_x ? t.v2.x : lo_x;
        lo_y = t.v0.y < t.v1.y ? t.v0.y : t.v1.y;
        lo_y = t.v2.y < lo_y ? t.v2.y : lo_y;
        hi_x = t.v0.x > t.v1.x ? t.v0.x : t.v1.x;
        hi_x = t.v2.x > hi_x ? t.v2.x : hi_x;
        hi_y = t.v0.y > t.v1.y ? t.v0.y : t.v1.y;
        hi_y = t.v2.y > hi_y ? t.v2.y : hi_y;
        hi_x = hi_x > SCREEN_W - 1 ? SCREEN_W - 1 : hi_x;
        hi_y = hi_y > SCREEN_H - 1 ? SCREEN_H - 1 : hi_y;
        if (lo_x > hi_x || lo_y > hi_y)
            return 0;
        return (hi_x - lo_x + 1) * (hi_y - lo_y + 1);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference rasterizer, raster order over the clipped box
    //////////////////////////////////////////////////////////////////////

    function automatic void rasterize_ref(input triangle_t t);
        int        x0, y0, x1, y1, x2, y2;
        int        area, lo_x, lo_y, hi_x, hi_y;
        int        px, py, w0, w1, w2;
        fragment_t f;
        x0 = t.v0.x;
        y0 = t.v0.y;
        x1 = t.v1.x;
        y1 = t.v1.y;
        x2 = t.v2.x;
        y2 = t.v2.y;
        area = edge_fn(x0, y0, x1, y1, x2, y2);
        if (area <= 0 || box_pixels(t) == 0)
            return;
        lo_x = x0 < x1 ? x0 : x1;
        lo_x = x2 < lo_x ? x2 : lo_x;
        lo_y = y0 < y1 ? y0 : y1;
        lo_y = y2 < lo_y ? y2 : lo_y;
        hi_x = x0 > x1 ? x0 : x1;
        hi_x = x2 > hi_x ? x2 : hi_x;
        hi_y = y0 > y1 ? y0 : y1;
        hi_y = y2 > hi_y ? y2 : hi_y;
        hi_x = hi_x > SCREEN_W - 1 ? SCREEN_W - 1 : hi_x;
        hi_y = hi_y > SCREEN_H - 1 ? SCREEN_H - 1 : hi_y;
        for (py = lo_y; py <= hi_y; py++)
        begin
            for (px = lo_x; px <= hi_x; px++)
            begin
                w0 = edge_fn(x1, y1, x2, y2, px, py);
                w1 = edge_fn(x2, y2, x0, y0, px, py);
                w2 = edge_fn(x0, y0, x1, y1, px, py);
                // Edge pixels are inside
                if (w0 >= 0 && w1 >= 0 && w2 >= 0)
                begin
                    f.x = 10'(px);
                    f.y = 9'(py);
                    f.color.r = 8'((w0 * t.colors.c0.r + w1 * t.colors.c1.r
                                  + w2 * t.colors.c2.r) / area);
                    f.color.g = 8'((w0 * t.colors.c0.g + w1 * t.colors.c1.g
                                  + w2 * t.colors.c2.g) / area);
                    f.color.b = 8'((w0 * t.colors.c0.b + w1 * t.colors.c1.b
                                  + w2 * t.colors.c2.b) / area);
                    exp_q.push_back(f);
                end
            end
        end
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (expected !== actual)
        begin
            error_count++;
            $display("ERR %s %s: expected %0h, actual %0h", name_list[0], what,
                     expected, actual);
        end
    endtask

    task automatic add_test(input string name, input int group, input triangle_t t);
        tri_list.push_back(t);
        name_list.push_back(name);
        group_list.push_back(group);
    endtask

    task automatic build_tests();
        int k;
        add_test("solid_right", 1, make_tri(10, 10, 20, 10, 10, 20, rgb(64, 128, 192),
                 rgb(64, 128, 192), rgb(64, 128, 192)));
        add_test("gouraud_a", 2, make_tri(100, 50, 160, 80, 90, 120, rgb(255, 0, 0),
                 rgb(0, 255, 0), rgb(0, 0, 255)));
        add_test("gouraud_b", 2, make_tri(30, 200, 75, 190, 50, 240, rgb(17, 200, 90),
                 rgb(250, 3, 128), rgb(60, 77, 255)));
        add_test("clip_edge", 3, make_tri(600, 440, 700, 450, 620, 520, rgb(10, 20, 30),
                 rgb(200, 100, 50), rgb(90, 250, 140)));
        add_test("clip_off", 3, make_tri(650, 100, 700, 100, 650, 150, rgb(1, 2, 3),
                 rgb(4, 5, 6), rgb(7, 8, 9)));
        add_test("clockwise", 4, make_tri(10, 10, 10, 20, 20, 10, rgb(9, 9, 9),
                 rgb(9, 9, 9), rgb(9, 9, 9)));
        add_test("collinear", 4, make_tri(5, 5, 10, 10, 20, 20, rgb(9, 9, 9),
                 rgb(9, 9, 9), rgb(9, 9, 9)));
        add_test("point", 4, make_tri(30, 30, 30, 30, 30, 30, rgb(9, 9, 9),
                 rgb(9, 9, 9), rgb(9, 9, 9)));
        add_test("backpressure", 5, make_tri(200, 100, 240, 105, 210, 140, rgb(255, 128, 0),
                 rgb(0, 64, 255), rgb(128, 255, 32)));
        for (k = 0; k < 20; k++)
            add_test($sformatf("random_%0d", k), 6, make_random_triangle());
    endtask

    // Strobe, then optional ignored strobes while busy, then drain
    task automatic run_triangle(input triangle_t t, input logic junk, output int n_exp);
        @(posedge clk);
        #2;
        while (busy)
        begin
            @(posedge clk);
            #2;
        end
        rasterize_ref(t);
        n_exp = exp_q.size();
        tri_data  = t;
        tri_valid = 1'b1;
        @(posedge clk);
        #2;
        tri_valid = 1'b0;
        check_value("busy after strobe", 1, busy);
        while (busy || exp_q.size() != 0)
        begin
            if (junk && busy)
            begin
                tri_data  = make_random_triangle();
                tri_valid = 1'(take_bits(lfsr_state, 1));
            end
            @(posedge clk);
            #2;
            tri_valid = 1'b0;
        end
        repeat (3) @(negedge clk);
        check_value("fifo empty after test", 0, frag_valid);
        check_value("busy idle after test", 0, busy);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output side
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk)
    begin
        #2;
        if (!ready_random)
            frag_ready = 1'b1;
        else
        begin
            if (seg_left == 0)
            begin
                seg_level = 1'(take_bits(ready_lfsr, 1));
                seg_left  = 16 + take_bits(ready_lfsr, 8);
            end
            seg_left   = seg_left - 1;
            frag_ready = seg_level;
        end
    end

    always @(negedge clk)
    begin
        if (raster_top_inst.full)
            full_seen = 1'b1;
        if (!rst && frag_valid && frag_ready)
        begin
            frag_count++;
            if (exp_q.size() == 0)
            begin
                error_count++;
                $display("%s: fragment at x %0d y %0d arrived when none was expected",
                         name_list[0], frag.x, frag.y);
            end
            else
            begin
                expect_frag = exp_q.pop_front();
                check_value("x", expect_frag.x, frag.x);
                check_value("y", expect_frag.y, frag.y);
                check_value("color", expect_frag.color, frag.color);
                check_value("x on screen", 1, frag.x < SCREEN_W);
                check_value("y on screen", 1, frag.y < SCREEN_H);
            end
        end
    end

    initial
    begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles with the run unfinished", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial
    begin
        int    total;
        int    err_before;
        int    n_exp;
        int    i;
        string name;
        rst          = 1'b1;
        tri_valid    = 1'b0;
        tri_data     = '0;
        frag_ready   = 1'b0;
        lfsr_state   = 32'hd6b;
        ready_lfsr   = 32'hd6b;
        ready_random = 1'b0;
        seg_left     = 0;
        seg_level    = 1'b1;
        full_seen    = 1'b0;
        error_count  = 0;
        check_count  = 0;
        frag_count   = 0;
        limit_cycles = 0;
        build_tests();
        total = 200;
        foreach (tri_list[k])
            total += box_pixels(tri_list[k]) * 40 + 400;
        limit_cycles = total;

        repeat (5) @(posedge clk);
        #2;
        rst = 1'b0;

        for (i = 0; i < tri_list.size(); i++)
        begin
            name = name_list[i];
            // Current test name sits at the queue head for error lines
            name_list[0] = name;
            if (group_list[i] == 5)
            begin
                seg_left  = 400;
                seg_level = 1'b0;
            end
            ready_random = (group_list[i] == 5);
            full_seen    = 1'b0;
            err_before   = error_count;
            frag_count   = 0;
            run_triangle(tri_list[i], group_list[i] == 5, n_exp);
            if (group_list[i] == 5)
                check_value("fifo reached full", 1, full_seen);
            check_value("fragment count", n_exp, frag_count);
            $display("%s: %0d expected, %0d received, %0d errors", name, n_exp,
                     frag_count, error_count - err_before);
        end

        $display("%0d tests, %0d checks, %0d errors", tri_list.size(), check_count,
                 error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

/* src/raster_top.sv */
module raster_top
    import shading_pkg::*, geometry_pkg::*;
#(
    parameter int X_BITS     = 10,
    parameter int Y_BITS     = 9,
    parameter int SCREEN_W   = 640,
    parameter int SCREEN_H   = 480,
    parameter int FIFO_DEPTH = 16
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      tri_valid,
    input  triangle_t tri_data,
    output logic      busy,
    output logic      frag_valid,
    output fragment_t frag,
    input  logic      frag_ready
);

    logic                 accept;
    logic                 setup_valid;
    edge_setup_t          setup;
    logic                 shade_start;
    weights_t             weights;
    logic [EDGE_BITS-1:0] area;
    tri_colors_t          colors;
    logic                 shade_done;
    color_t               shade_color;
    logic                 full;
    logic                 wr_en;
    fragment_t            wr_frag;

    tri_setup #(.SCREEN_W(SCREEN_W), .SCREEN_H(SCREEN_H)) tri_setup_inst (
        .clk         (clk),
        .rst         (rst),
        .tri_valid   (tri_valid),
        .tri_data    (tri_data),
        .accept      (accept),
        .setup_valid (setup_valid),
        .setup       (setup)
    );

    edge_walker #(.X_BITS(X_BITS), .Y_BITS(Y_BITS)) edge_walker_inst (
        .clk         (clk),
        .rst         (rst),
        .setup_valid (setup_valid),
        .setup       (setup),
        .accept      (accept),
        .busy        (busy),
        .shade_start (shade_start),
        .weights     (weights),
        .area        (area),
        .colors      (colors),
        .shade_done  (shade_done),
        .shade_color (shade_color),
        .full        (full),
        .wr_en       (wr_en),
        .wr_frag     (wr_frag)
    );

    color_interp color_interp_inst (
        .clk         (clk),
        .rst         (rst),
        .shade_start (shade_start),
        .weights     (weights),
        .area        (area),
        .colors      (colors),
        .shade_done  (shade_done),
        .shade_color (shade_color)
    );

    frag_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) frag_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .wr_en      (wr_en),
        .wr_frag    (wr_frag),
        .full       (full),
        .frag_valid (frag_valid),
        .frag       (frag),
        .frag_ready (frag_ready)
    );

endmodule

/* src/frag_fifo.sv */
module frag_fifo
    import shading_pkg::*;
#(
    parameter int FIFO_DEPTH = 16
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      wr_en,
    input  fragment_t wr_frag,
    output logic      full,
    output logic      frag_valid,
    output fragment_t frag,
    input  logic      frag_ready
);

    localparam int PTR_BITS = $clog2(FIFO_DEPTH);
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    fragment_t           mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr, rd_ptr;
    logic [CNT_BITS-1:0] count;
    logic                push, pop;

    function automatic logic [PTR_BITS-1:0] ptr_next(input logic [PTR_BITS-1:0] p);
        if (p == PTR_BITS'(FIFO_DEPTH - 1))
            ptr_next = '0;
        else
            ptr_next = p + 1'b1;
    endfunction

    assign full       = (count == CNT_BITS'(FIFO_DEPTH));
    assign frag_valid = (count != '0);
    // Head word shown without a read request
    assign frag       = mem[rd_ptr];
    assign push       = wr_en && !full;
    assign pop        = frag_valid && frag_ready;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= ptr_next(wr_ptr);
            if (pop)
                rd_ptr <= ptr_next(rd_ptr);
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= wr_frag;
    end

endmodule

/* src/edge_walker.sv */
module edge_walker
    import shading_pkg::*, geometry_pkg::*;
#(
    parameter int X_BITS = 10,
    parameter int Y_BITS = 9
)
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 setup_valid,
    input  edge_setup_t          setup,
    output logic                 accept,
    output logic                 busy,
    output logic                 shade_start,
    output weights_t             weights,
    output logic [EDGE_BITS-1:0] area,
    output tri_colors_t          colors,
    input  logic                 shade_done,
    input  color_t               shade_color,
    input  logic                 full,
    output logic                 wr_en,
    output fragment_t            wr_frag
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ROW,
        ST_PIXEL,
        ST_SHADE,
        ST_WRITE
    } state_t;

    state_t                      state;
    state_t                      next_pos;
    edge_setup_t                 setup_r;
    logic [X_BITS-1:0]           x_cnt;
    logic [Y_BITS-1:0]           y_cnt;
    logic signed [EDGE_BITS-1:0] row_w0, row_w1, row_w2;
    logic signed [EDGE_BITS-1:0] pix_w0, pix_w1, pix_w2;
    logic                        covered, last_x, last_y, advance;

    // A pending setup counts as busy so a second strobe is not taken
    assign accept = (state == ST_IDLE) && !setup_valid;
    assign busy   = (state != ST_IDLE) || setup_valid;

    // Pixels on an edge count as inside
    assign covered = !pix_w0[EDGE_BITS-1] && !pix_w1[EDGE_BITS-1] && !pix_w2[EDGE_BITS-1];
    assign last_x  = (x_cnt == setup_r.box.max_x[X_BITS-1:0]);
    assign last_y  = (y_cnt == setup_r.box.max_y[Y_BITS-1:0]);
    assign advance = ((state == ST_PIXEL) && !covered) || ((state == ST_WRITE) && !full);

    always_comb
    begin
        if (!last_x)
            next_pos = ST_PIXEL;
        else if (last_y)
            next_pos = ST_IDLE;
        else
            next_pos = ST_ROW;
    end

    assign shade_start = (state == ST_PIXEL) && covered;
    assign weights     = '{w0: pix_w0, w1: pix_w1, w2: pix_w2};
    assign area        = setup_r.area;
    assign colors      = setup_r.colors;
    assign wr_en       = (state == ST_WRITE) && !full;

    always_ff @(posedge clk)
    begin
        if (rst)
            state <= ST_IDLE;
        else
            case (state)
                ST_IDLE:
                    if (setup_valid && !setup.empty)
                        state <= ST_ROW;
                ST_ROW:
                    state <= ST_PIXEL;
                ST_PIXEL:
                    state <= covered ? ST_SHADE : next_pos;
                ST_SHADE:
                    if (shade_done)
                        state <= ST_WRITE;
                ST_WRITE:
                    if (!full)
                        state <= next_pos;
                default:
                    state <= ST_IDLE;
            endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Position and incremental edge values
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if ((state == ST_IDLE) && setup_valid)
        begin
            setup_r <= setup;
            row_w0  <= setup.w0;
            row_w1  <= setup.w1;
            row_w2  <= setup.w2;
            y_cnt   <= setup.box.min_y[Y_BITS-1:0];
        end
        else if (state == ST_ROW)
        begin
            pix_w0 <= row_w0;
            pix_w1 <= row_w1;
            pix_w2 <= row_w2;
            x_cnt  <= setup_r.box.min_x[X_BITS-1:0];
        end
        else if (advance && !last_x)
        begin
            pix_w0 <= pix_w0 + setup_r.s0.step_x;
            pix_w1 <= pix_w1 + setup_r.s1.step_x;
            pix_w2 <= pix_w2 + setup_r.s2.step_x;
            x_cnt  <= x_cnt + 1'b1;
        end
        else if (advance)
        begin
            row_w0 <= row_w0 + setup_r.s0.step_y;
            row_w1 <= row_w1 + setup_r.s1.step_y;
            row_w2 <= row_w2 + setup_r.s2.step_y;
            y_cnt  <= y_cnt + 1'b1;
        end

        if ((state == ST_SHADE) && shade_done)
            wr_frag <= '{x: x_cnt, y: y_cnt, color: shade_color};
    end

endmodule

/* src/color_interp.sv */
module color_interp
    import shading_pkg::*, geometry_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 shade_start,
    input  weights_t             weights,
    input  logic [EDGE_BITS-1:0] area,
    input  tri_colors_t          colors,
    output logic                 shade_done,
    output color_t               shade_color
);

    // Sum of three weights never exceeds the area, so 8 extra bits suffice
    localparam int SUM_BITS = EDGE_BITS + 8;

    logic [SUM_BITS-1:0]  sum_r, sum_g, sum_b;
    logic [EDGE_BITS-1:0] area_r;
    logic                 div_start;
    logic                 done_r, done_g, done_b;

    function automatic logic [SUM_BITS-1:0] channel_sum(
        input weights_t   w,
        input logic [7:0] c0, c1, c2
    );
        channel_sum = SUM_BITS'(w.w0) * SUM_BITS'(c0)
                    + SUM_BITS'(w.w1) * SUM_BITS'(c1)
                    + SUM_BITS'(w.w2) * SUM_BITS'(c2);
    endfunction

    always_ff @(posedge clk)
    begin
        if (rst)
            div_start <= 1'b0;
        else
            div_start <= shade_start;
    end

    always_ff @(posedge clk)
    begin
        if (shade_start)
        begin
            sum_r  <= channel_sum(weights, colors.c0.r, colors.c1.r, colors.c2.r);
            sum_g  <= channel_sum(weights, colors.c0.g, colors.c1.g, colors.c2.g);
            sum_b  <= channel_sum(weights, colors.c0.b, colors.c1.b, colors.c2.b);
            area_r <= area;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // One divider per channel, all in lock step
    //////////////////////////////////////////////////////////////////////

    shade_divider #(.DIVIDEND_BITS(SUM_BITS), .DIVISOR_BITS(EDGE_BITS)) div_r_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (sum_r),
        .divisor  (area_r),
        .done     (done_r),
        .quotient (shade_color.r)
    );

    shade_divider #(.DIVIDEND_BITS(SUM_BITS), .DIVISOR_BITS(EDGE_BITS)) div_g_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (sum_g),
        .divisor  (area_r),
        .done     (done_g),
        .quotient (shade_color.g)
    );

    shade_divider #(.DIVIDEND_BITS(SUM_BITS), .DIVISOR_BITS(EDGE_BITS)) div_b_inst (
        .clk      (clk),
        .rst      (rst),
        .start    (div_start),
        .dividend (sum_b),
        .divisor  (area_r),
        .done     (done_b),
        .quotient (shade_color.b)
    );

    assign shade_done = done_r && done_g && done_b;

endmodule

/* src/shade_divider.sv */
module shade_divider
#(
    parameter int DIVIDEND_BITS = 30,
    parameter int DIVISOR_BITS  = 22
)
(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     start,
    input  logic [DIVIDEND_BITS-1:0] dividend,
    input  logic [DIVISOR_BITS-1:0]  divisor,
    output logic                     done,
    output logic [7:0]               quotient
);

    logic [DIVIDEND_BITS-1:0] rem;
    logic [DIVIDEND_BITS-1:0] div_sh;
    logic [DIVIDEND_BITS:0]   trial;
    logic [2:0]               bit_cnt;
    logic                     active;

    // Trial subtraction, negative result restores the remainder
    assign trial = {1'b0, rem} - {1'b0, div_sh};

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            active  <= 1'b0;
            done    <= 1'b0;
            bit_cnt <= '0;
        end
        else
        begin
            done <= active && (bit_cnt == 3'd0);
            if (start)
            begin
                active  <= 1'b1;
                bit_cnt <= 3'd7;
            end
            else if (active)
            begin
                bit_cnt <= bit_cnt - 1'b1;
                if (bit_cnt == 3'd0)
                    active <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (start)
        begin
            rem    <= dividend;
            div_sh <= DIVIDEND_BITS'(divisor) << 7;
        end
        else if (active)
        begin
            if (!trial[DIVIDEND_BITS])
                rem <= trial[DIVIDEND_BITS-1:0];
            quotient <= {quotient[6:0], !trial[DIVIDEND_BITS]};
            div_sh   <= div_sh >> 1;
        end
    end

endmodule

/* src/tri_setup.sv */
module tri_setup
    import geometry_pkg::*;
#(
    parameter int SCREEN_W = 640,
    parameter int SCREEN_H = 480
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        tri_valid,
    input  triangle_t   tri_data,
    input  logic        accept,
    output logic        setup_valid,
    output edge_setup_t setup
);

    localparam logic [COORD_BITS-1:0] X_LAST = COORD_BITS'(SCREEN_W - 1);
    localparam logic [COORD_BITS-1:0] Y_LAST = COORD_BITS'(SCREEN_H - 1);

    logic signed [EDGE_BITS-1:0] x0, y0, x1, y1, x2, y2;
    logic signed [EDGE_BITS-1:0] ox, oy;
    logic signed [EDGE_BITS-1:0] area;
    logic [COORD_BITS-1:0]       lo_x, lo_y, hi_x, hi_y;
    edge_setup_t                 setup_next;

    // Edge a->b evaluated at p
    function automatic logic signed [EDGE_BITS-1:0] edge_at(
        input logic signed [EDGE_BITS-1:0] xa, ya, xb, yb, px, py
    );
        edge_at = (xb - xa) * (py - ya) - (yb - ya) * (px - xa);
    endfunction

    function automatic logic [COORD_BITS-1:0] min3(input logic [COORD_BITS-1:0] a, b, c);
        min3 = (a < b) ? a : b;
        if (c < min3)
            min3 = c;
    endfunction

    function automatic logic [COORD_BITS-1:0] max3(input logic [COORD_BITS-1:0] a, b, c);
        max3 = (a > b) ? a : b;
        if (c > max3)
            max3 = c;
    endfunction

    assign x0 = EDGE_BITS'(tri_data.v0.x);
    assign y0 = EDGE_BITS'(tri_data.v0.y);
    assign x1 = EDGE_BITS'(tri_data.v1.x);
    assign y1 = EDGE_BITS'(tri_data.v1.y);
    assign x2 = EDGE_BITS'(tri_data.v2.x);
    assign y2 = EDGE_BITS'(tri_data.v2.y);

    //////////////////////////////////////////////////////////////////////
    // Box clipped to screen, edges at the box origin
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        lo_x = min3(tri_data.v0.x, tri_data.v1.x, tri_data.v2.x);
        lo_y = min3(tri_data.v0.y, tri_data.v1.y, tri_data.v2.y);
        hi_x = max3(tri_data.v0.x, tri_data.v1.x, tri_data.v2.x);
        hi_y = max3(tri_data.v0.y, tri_data.v1.y, tri_data.v2.y);
        if (hi_x > X_LAST)
            hi_x = X_LAST;
        if (hi_y > Y_LAST)
            hi_y = Y_LAST;

        ox = EDGE_BITS'(lo_x);
        oy = EDGE_BITS'(lo_y);
        area = edge_at(x0, y0, x1, y1, x2, y2);

        setup_next.box = '{min_x: lo_x, min_y: lo_y, max_x: hi_x, max_y: hi_y};
        setup_next.w0 = edge_at(x1, y1, x2, y2, ox, oy);
        setup_next.w1 = edge_at(x2, y2, x0, y0, ox, oy);
        setup_next.w2 = edge_at(x0, y0, x1, y1, ox, oy);
        setup_next.s0 = '{step_x: y1 - y2, step_y: x2 - x1};
        setup_next.s1 = '{step_x: y2 - y0, step_y: x0 - x2};
        setup_next.s2 = '{step_x: y0 - y1, step_y: x1 - x0};
        setup_next.area = area;
        setup_next.colors = tri_data.colors;
        // Clockwise, degenerate or fully off screen
        setup_next.empty = area[EDGE_BITS-1] || (area == '0) || (lo_x > hi_x) || (lo_y > hi_y);
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            setup_valid <= 1'b0;
        else
            setup_valid <= tri_valid && accept;
    end

    always_ff @(posedge clk)
    begin
        if (tri_valid && accept)
            setup <= setup_next;
    end

endmodule

/* src/geometry_pkg.sv */
package geometry_pkg;
    import shading_pkg::*;

    localparam int COORD_BITS = 10;
    // Signed width of edge values and area
    localparam int EDGE_BITS = 22;

    typedef struct packed {
        logic [COORD_BITS-1:0] x;
        logic [COORD_BITS-1:0] y;
    } vertex_t;

    typedef struct packed {
        vertex_t     v0;
        vertex_t     v1;
        vertex_t     v2;
        tri_colors_t colors;
    } triangle_t;

    typedef struct packed {
        logic [COORD_BITS-1:0] min_x;
        logic [COORD_BITS-1:0] min_y;
        logic [COORD_BITS-1:0] max_x;
        logic [COORD_BITS-1:0] max_y;
    } bbox_t;

    typedef struct packed {
        logic signed [EDGE_BITS-1:0] step_x;
        logic signed [EDGE_BITS-1:0] step_y;
    } edge_step_t;

    typedef struct packed {
        logic                        empty;
        bbox_t                       box;
        logic signed [EDGE_BITS-1:0] w0;
        logic signed [EDGE_BITS-1:0] w1;
        logic signed [EDGE_BITS-1:0] w2;
        edge_step_t                  s0;
        edge_step_t                  s1;
        edge_step_t                  s2;
        logic signed [EDGE_BITS-1:0] area;
        tri_colors_t                 colors;
    } edge_setup_t;

    typedef struct packed {
        logic [EDGE_BITS-1:0] w0;
        logic [EDGE_BITS-1:0] w1;
        logic [EDGE_BITS-1:0] w2;
    } weights_t;

endpackage

/* src/shading_pkg.sv */
package shading_pkg;

    // Fragment coordinate widths
    localparam int FRAG_X_BITS = 10;
    localparam int FRAG_Y_BITS = 9;

    typedef struct packed {
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } color_t;

    // One color per triangle vertex
    typedef struct packed {
        color_t c0;
        color_t c1;
        color_t c2;
    } tri_colors_t;

    typedef struct packed {
        logic [FRAG_X_BITS-1:0] x;
        logic [FRAG_Y_BITS-1:0] y;
        color_t                 color;
    } fragment_t;

endpackage
